/* rtl/sprite_pkg.sv */
/*
 * shared definitions for the sprite block; register bus is write only,
 * addresses are word addresses (bit 0 dropped), sprites are 16 pixels wide
 */

package sprite_pkg;

	//--------------------------------------------------------------------------
	// sizes
	//--------------------------------------------------------------------------

	localparam int NUM_SPRITES = 8;					// hardware sprites
	localparam int NUM_PAIRS   = NUM_SPRITES / 2;	// attachable pairs (0,1) .. (6,7)

	//--------------------------------------------------------------------------
	// register map
	//--------------------------------------------------------------------------

	// base of the sprite window, only bits 8..6 take part in the compare
	localparam logic [8:0] SPR_BASE = 9'h140;

	// per sprite offsets, taken from address bits 2..1
	localparam logic [1:0] REG_POS  = 2'd0;	// horizontal start bits 8..1
	localparam logic [1:0] REG_CTL  = 2'd1;	// attach, start bit 0, disarms
	localparam logic [1:0] REG_DATA = 2'd2;	// plane A word, arms
	localparam logic [1:0] REG_DATB = 2'd3;	// plane B word

	//--------------------------------------------------------------------------
	// types
	//--------------------------------------------------------------------------

	// one chip bus write, 25 bits
	typedef struct packed
	{
		logic			en;		// write strobe
		logic	[8:1]	addr;	// register address, word aligned
		logic	[15:0]	data;	// write data
	} reg_wr_t;

	// one sprite's current output, 3 bits
	typedef struct packed
	{
		logic	[1:0]	pix;	// {plane B, plane A}, 0 is transparent
		logic			attach;	// ctl bit 7 of this sprite
	} sprite_pix_t;

	// merged sprite colour index, 0 is transparent
	typedef logic [3:0] sprite_color_t;

endpackage

/* rtl/sprite_shifter.sv */
/*
 * one sprite channel; no vertical start/stop, data is written directly
 * load happens on the edge where hpos matches while armed, first pixel next cycle
 */
`timescale 1ns/1ps

module sprite_shifter
(
	input	logic					clk,
	input	logic					reset,
	input	sprite_pkg::reg_wr_t	wr,		// shared bus write
	input	logic					sel,	// address hits this sprite
	input	logic	[8:0]			hpos,	// horizontal beam counter
	output	sprite_pkg::sprite_pix_t	pix		// serial pixel and attach flag
);

	import sprite_pkg::*;

	//--------------------------------------------------------------------------
	// local signals
	//--------------------------------------------------------------------------

	logic	[8:0]	hstart;		// horizontal start position
	logic			attach;		// attached to its pair partner
	logic	[15:0]	datla;		// plane A latch
	logic	[15:0]	datlb;		// plane B latch
	logic			armed;		// waiting for / repeating on hstart
	logic	[15:0]	shift_a;	// plane A serializer
	logic	[15:0]	shift_b;	// plane B serializer
	logic			wr_hit;		// valid write to this sprite
	logic	[1:0]	offset;		// register within the sprite
	logic			load;		// reload serializers this edge

	assign wr_hit = sel && wr.en;
	assign offset = wr.addr[2:1];

	//--------------------------------------------------------------------------
	// arming
	//--------------------------------------------------------------------------

	// ctl write disarms, data A write arms; armed then stays set so the
	// sprite comes back on every line until the next ctl write
	always_ff @(posedge clk)
	begin
		if (reset)
			armed <= 1'b0;
		else if (wr_hit && offset == REG_CTL)
			armed <= 1'b0;
		else if (wr_hit && offset == REG_DATA)
			armed <= 1'b1;
	end

	// uses armed as it was before this edge
	assign load = armed && (hpos == hstart);

	//--------------------------------------------------------------------------
	// position and control
	//--------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (wr_hit && offset == REG_POS)
			hstart[8:1] <= wr.data[7:0];	// coarse start
		if (wr_hit && offset == REG_CTL)
			hstart[0] <= wr.data[0];		// fine start bit
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			attach <= 1'b0;
		else if (wr_hit && offset == REG_CTL)
			attach <= wr.data[7];
	end

	//--------------------------------------------------------------------------
	// data latches
	//--------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (wr_hit && offset == REG_DATA)
			datla <= wr.data;
		if (wr_hit && offset == REG_DATB)
			datlb <= wr.data;
	end

	//--------------------------------------------------------------------------
	// parallel to serial
	//--------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			shift_a <= '0;
			shift_b <= '0;
		end
		else if (load)	// grab latched words
		begin
			shift_a <= datla;
			shift_b <= datlb;
		end
		else			// msb first, zero fill -> transparent after 16
		begin
			shift_a <= {shift_a[14:0], 1'b0};
			shift_b <= {shift_b[14:0], 1'b0};
		end
	end

	// plane B is the high pixel bit
	assign pix.pix    = {shift_b[15], shift_a[15]};
	assign pix.attach = attach;

endmodule

/* rtl/sprite_priority.sv */
/*
 * purely combinational merge of the eight sprite pixels
 * fixed priority, sprite 0 highest; attach from either sprite of a pair counts
 */
`timescale 1ns/1ps

module sprite_priority
(
	input	logic							sprena,	// sprite display enable
	input	sprite_pkg::sprite_pix_t		pix [sprite_pkg::NUM_SPRITES],
	output	logic	[sprite_pkg::NUM_SPRITES-1:0]	nsprite,	// opaque mask
	output	sprite_pkg::sprite_color_t		sprdata	// merged colour
);

	import sprite_pkg::*;

	//--------------------------------------------------------------------------
	// local signals
	//--------------------------------------------------------------------------

	logic	[NUM_SPRITES-1:0]	opaque;		// per sprite, nonzero and enabled
	logic	[NUM_PAIRS-1:0]		pair_hit;	// any sprite of the pair opaque
	sprite_color_t				pair_color [NUM_PAIRS];	// colour if pair wins

	//--------------------------------------------------------------------------
	// opaque mask
	//--------------------------------------------------------------------------

	genvar i;
	generate
		for (i = 0; i < NUM_SPRITES; i++)
		begin : g_opaque
			// sprena low blanks every sprite
			assign opaque[i] = sprena && (pix[i].pix != 2'b00);
		end
	endgenerate

	assign nsprite = opaque;

	//--------------------------------------------------------------------------
	// per pair colour
	//--------------------------------------------------------------------------

	genvar p;
	generate
		for (p = 0; p < NUM_PAIRS; p++)
		begin : g_pair
			logic	attached;	// either partner has ctl bit 7 set

			assign attached    = pix[2*p].attach || pix[2*p+1].attach;
			assign pair_hit[p] = opaque[2*p] || opaque[2*p+1];

			always_comb
			begin
				if (attached)				// 15 colours + transparent
					pair_color[p] = {pix[2*p+1].pix, pix[2*p].pix};
				else if (opaque[2*p])		// even sprite in front
					pair_color[p] = {2'(p), pix[2*p].pix};
				else						// odd sprite, or nothing
					pair_color[p] = {2'(p), pix[2*p+1].pix};
			end
		end
	endgenerate

	//--------------------------------------------------------------------------
	// pair priority
	//--------------------------------------------------------------------------

	// lowest numbered pair with anything visible wins
	always_comb
	begin : prio
		logic	found;

		found   = 1'b0;
		sprdata = '0;	// all transparent
		for (int k = 0; k < NUM_PAIRS; k++)
		begin
			if (!found && pair_hit[k])
			begin
				found   = 1'b1;
				sprdata = pair_color[k];
			end
		end
	end

endmodule

/* rtl/denise_sprites.sv */
/*
 * sprite block top; writes are accepted every cycle with no back-pressure
 * registers sit at 0x140..0x17e, four words per sprite, outputs are combinational
 */
`timescale 1ns/1ps

module denise_sprites
(
	input	logic						clk,
	input	logic						reset,
	input	sprite_pkg::reg_wr_t		wr,			// chip register bus write
	input	logic	[8:0]				hpos,		// horizontal beam counter
	input	logic						sprena,		// sprite enable
	output	logic	[7:0]				nsprite,	// opaque sprite mask
	output	sprite_pkg::sprite_color_t	sprdata		// sprite colour index
);

	import sprite_pkg::*;

	//--------------------------------------------------------------------------
	// local signals
	//--------------------------------------------------------------------------

	logic							base_hit;	// address in sprite window
	logic	[NUM_SPRITES-1:0]		sel;		// one select per sprite
	sprite_pix_t					pix [NUM_SPRITES];	// shifter outputs
	logic	[NUM_SPRITES-1:0]		mask;		// opaque mask from priority
	sprite_color_t					color;		// merged colour

	//--------------------------------------------------------------------------
	// address decode
	//--------------------------------------------------------------------------

	// bits 8..6 pick the window, 5..3 the sprite, 2..1 go on to the shifter
	assign base_hit = (wr.addr[8:6] == SPR_BASE[8:6]);

	genvar i;
	generate
		for (i = 0; i < NUM_SPRITES; i++)
		begin : g_sprite
			// write enable is qualified inside the shifter
			assign sel[i] = base_hit && (wr.addr[5:3] == 3'(i));

			sprite_shifter u_shifter
			(
				.clk	(clk),
				.reset	(reset),
				.wr		(wr),
				.sel	(sel[i]),
				.hpos	(hpos),
				.pix	(pix[i])
			);
		end
	endgenerate

	//--------------------------------------------------------------------------
	// priority and colour merge
	//--------------------------------------------------------------------------

	sprite_priority u_priority
	(
		.sprena		(sprena),
		.pix		(pix),
		.nsprite	(mask),
		.sprdata	(color)
	);

	assign nsprite = mask;	// no output stage, zero latency
	assign sprdata = color;

endmodule

/* dv/denise_sprites_props.sv */
/*
 * assertions for one sprite channel, bound into every sprite_shifter
 */
`timescale 1ns/1ps

module denise_sprites_props
(
	input	logic					clk,
	input	logic					reset,
	input	sprite_pkg::reg_wr_t	wr,
	input	logic					sel,
	input	logic					armed,
	input	logic	[15:0]			shift_a,
	input	logic	[15:0]			shift_b
);

	import sprite_pkg::*;

	logic	ctl_write;	// ctl register of this sprite written

	assign ctl_write = sel && wr.en && (wr.addr[2:1] == REG_CTL);

	a_reset_clear: assert property (@(posedge clk)
		reset |=> (shift_a == '0 && shift_b == '0))
		else $error("shift registers not cleared by reset");

	a_ctl_disarms: assert property (@(posedge clk) disable iff (reset)
		ctl_write |=> !armed)
		else $error("sprite still armed after a ctl write");

	// disarmed, so only the plain zero fill shift
	a_no_load: assert property (@(posedge clk) disable iff (reset)
		!armed |=> (shift_a == ($past(shift_a) << 1) && shift_b == ($past(shift_b) << 1)))
		else $error("disarmed sprite loaded its shift registers");

endmodule

bind sprite_shifter denise_sprites_props u_props
(
	.clk		(clk),
	.reset		(reset),
	.wr			(wr),
	.sel		(sel),
	.armed		(armed),
	.shift_a	(shift_a),
	.shift_b	(shift_b)
);

/* dv/tb_denise_sprites.sv */
/*
 * testbench for the sprite block; hpos wraps at 454, inputs change on the falling edge
 * every cycle is compared with a reference model, random phase runs from a fixed seed
 */
`timescale 1ns/1ps

module tb_denise_sprites;

	import sprite_pkg::*;

	localparam int			CLK_PERIOD = 100;					// ns
	localparam int			LINE_LEN   = 455;					// clocks per scan line
	localparam logic [8:0]	LAST_HPOS  = 9'd454;
	localparam int			RAND_LINES = 8;
	localparam int			TEST_LINES = 14 + RAND_LINES;		// directed + random
	localparam int			TIMEOUT    = (TEST_LINES + 4) * LINE_LEN * CLK_PERIOD;

	logic			clk;
	logic			reset;
	reg_wr_t		wr;
	logic	[8:0]	hpos;
	logic			sprena;
	logic	[7:0]	nsprite;
	sprite_color_t	sprdata;

	integer	seed;
	bit		checking;		// off until reset is done
	int		checks;
	int		mask_errors;
	int		color_errors;

	// reference model, one entry per sprite
	logic	[8:0]	m_start  [NUM_SPRITES];
	logic			m_attach [NUM_SPRITES];
	logic	[15:0]	m_data_a [NUM_SPRITES];
	logic	[15:0]	m_data_b [NUM_SPRITES];
	logic			m_armed  [NUM_SPRITES];
	logic	[15:0]	m_sh_a   [NUM_SPRITES];
	logic	[15:0]	m_sh_b   [NUM_SPRITES];

	denise_sprites u_dut
	(
		.clk		(clk),
		.reset		(reset),
		.wr			(wr),
		.hpos		(hpos),
		.sprena		(sprena),
		.nsprite	(nsprite),
		.sprdata	(sprdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//--------------------------------------------------------------------------
	// reference model
	//--------------------------------------------------------------------------

	always @(posedge clk)
	begin
		logic			hit;
		logic	[2:0]	spr;
		logic	[1:0]	off;

		hit = wr.en && (wr.addr[8:6] == SPR_BASE[8:6]);
		spr = wr.addr[5:3];
		off = wr.addr[2:1];
		for (int s = 0; s < NUM_SPRITES; s++)
		begin
			if (reset)
			begin
				m_armed[s]  = 1'b0;
				m_attach[s] = 1'b0;
				m_sh_a[s]   = '0;
				m_sh_b[s]   = '0;
			end
			else
			begin
				// load decision sees the registers from before this edge
				if (m_armed[s] && hpos == m_start[s])
				begin
					m_sh_a[s] = m_data_a[s];
					m_sh_b[s] = m_data_b[s];
				end
				else
				begin
					m_sh_a[s] = m_sh_a[s] << 1;
					m_sh_b[s] = m_sh_b[s] << 1;
				end
				if (hit && spr == 3'(s))
					case (off)
						REG_POS:	m_start[s][8:1] = wr.data[7:0];
						REG_CTL:
						begin
							m_start[s][0] = wr.data[0];
							m_attach[s]   = wr.data[7];
							m_armed[s]    = 1'b0;
						end
						REG_DATA:
						begin
							m_data_a[s] = wr.data;
							m_armed[s]  = 1'b1;
						end
						default:	m_data_b[s] = wr.data;
					endcase
			end
		end
	end

	// mask and colour from the model by the pair priority rule
	task automatic expected_outputs(output logic [7:0] mask, output sprite_color_t color);
		logic	[1:0]	px [NUM_SPRITES];
		logic			done;

		done  = 1'b0;
		color = '0;
		for (int s = 0; s < NUM_SPRITES; s++)
		begin
			px[s]   = {m_sh_b[s][15], m_sh_a[s][15]};
			mask[s] = sprena && (px[s] != 2'b00);
		end
		for (int p = 0; p < NUM_PAIRS; p++)
		begin
			if (!done && (mask[2*p] || mask[2*p+1]))
			begin
				done = 1'b1;
				if (m_attach[2*p] || m_attach[2*p+1])
					color = {px[2*p+1], px[2*p]};	// odd sprite is the high half
				else if (mask[2*p])
					color = {2'(p), px[2*p]};
				else
					color = {2'(p), px[2*p+1]};
			end
		end
	endtask

	//--------------------------------------------------------------------------
	// checks
	//--------------------------------------------------------------------------

	task automatic check_mask(input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp)
		begin
			mask_errors++;
			$display("error at %0d ns: nsprite expected %b, got %b", $time, exp, act);
		end
	endtask

	task automatic check_color(input sprite_color_t exp, input sprite_color_t act);
		checks++;
		if (act !== exp)
		begin
			color_errors++;
			$display("error at %0d ns: sprdata expected %h, got %h", $time, exp, act);
		end
	endtask

	always @(negedge clk)
	begin
		logic	[7:0]	exp_mask;
		sprite_color_t	exp_color;

		#1;	// inputs of this edge have settled
		if (checking)
		begin
			expected_outputs(exp_mask, exp_color);
			check_mask(exp_mask, nsprite);
			check_color(exp_color, sprdata);
		end
	end

	//--------------------------------------------------------------------------
	// stimulus tasks
	//--------------------------------------------------------------------------

	task automatic step(input reg_wr_t w);
		@(negedge clk);
		hpos = (hpos == LAST_HPOS) ? 9'd0 : hpos + 9'd1;	// beam counter
		wr   = w;
	endtask

	task automatic run_lines(input int n);
		repeat (n * LINE_LEN) step('0);
	endtask

	task automatic wait_hpos(input logic [8:0] target);
		while (hpos != target)
			step('0);
	endtask

	task automatic write_reg(input int spr, input logic [1:0] off, input logic [15:0] data);
		reg_wr_t	w;

		w.en   = 1'b1;
		w.addr = {SPR_BASE[8:6], 3'(spr), off};
		w.data = data;
		step(w);
	endtask

	task automatic setup_sprite(input int spr, input logic [8:0] start, input logic att,
		input logic [15:0] a, input logic [15:0] b);
		write_reg(spr, REG_POS, {8'h00, start[8:1]});
		write_reg(spr, REG_CTL, {8'h00, att, 6'h00, start[0]});
		write_reg(spr, REG_DATB, b);
		write_reg(spr, REG_DATA, a);	// arms last
	endtask

	task automatic random_write;
		logic	[31:0]	r1;
		logic	[31:0]	r2;
		reg_wr_t		w;

		r1 = $random(seed);
		r2 = $random(seed);
		w.en   = 1'b1;
		w.addr = r1[7:0];
		w.data = r2[15:0];
		if (r1[10:8] != 3'd0)
			w.addr[8:6] = SPR_BASE[8:6];	// mostly in the window
		else if (w.addr[8:6] == SPR_BASE[8:6])
			w.addr[8] = ~w.addr[8];			// force a miss
		step(w);
	endtask

	//--------------------------------------------------------------------------
	// test sequence
	//--------------------------------------------------------------------------

	initial
	begin
		logic	[31:0]	rnd;

		seed         = 32'he51c_ba59;
		checking     = 1'b0;
		checks       = 0;
		mask_errors  = 0;
		color_errors = 0;
		reset        = 1'b1;
		wr           = '0;
		hpos         = 9'd0;
		sprena       = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset    = 1'b0;
		checking = 1'b1;

		run_lines(1);	// nothing armed, all transparent
		for (int s = 0; s < NUM_SPRITES; s++)
		begin
			write_reg(s, REG_POS, 16'h00ff);	// no DATA write, stays disarmed
			write_reg(s, REG_CTL, 16'h0000);
			write_reg(s, REG_DATB, 16'h0000);
		end

		// single sprite, odd start, seen on two lines
		setup_sprite(3, 9'd101, 1'b0, 16'hf0a5, 16'h3c0f);
		wait_hpos(LAST_HPOS);
		run_lines(2);

		// overlap across pairs (1 and 4), then within pair 3
		wait_hpos(9'd400);
		setup_sprite(1, 9'd200, 1'b0, 16'hffff, 16'h0000);
		setup_sprite(4, 9'd204, 1'b0, 16'h0f0f, 16'hffff);
		setup_sprite(6, 9'd300, 1'b0, 16'haaaa, 16'h0000);
		setup_sprite(7, 9'd302, 1'b0, 16'hffff, 16'hffff);
		wait_hpos(LAST_HPOS);
		run_lines(2);

		// attached pairs, attach on the even and on the odd sprite
		wait_hpos(9'd400);
		setup_sprite(2, 9'd60, 1'b1, 16'hf00f, 16'hff00);
		setup_sprite(3, 9'd60, 1'b0, 16'h0f0f, 16'h00ff);
		setup_sprite(4, 9'd150, 1'b0, 16'h3333, 16'h5555);
		setup_sprite(5, 9'd152, 1'b1, 16'hff00, 16'h0ff0);
		wait_hpos(LAST_HPOS);
		run_lines(2);

		// ctl write disarms, then sprite enable off
		wait_hpos(9'd400);
		write_reg(1, REG_CTL, 16'h0000);
		write_reg(6, REG_CTL, 16'h0000);
		wait_hpos(LAST_HPOS);
		run_lines(1);
		sprena = 1'b0;
		run_lines(1);
		sprena = 1'b1;

		// random writes, some outside the window
		repeat (RAND_LINES * LINE_LEN)
		begin
			rnd = $random(seed);
			if (rnd[1:0] == 2'd0)
				random_write();
			else
				step('0);
			if (rnd[12:6] == 7'd0)
				sprena = ~sprena;	// occasional blanking
		end

		$display("checks %0d, nsprite errors %0d, sprdata errors %0d",
			checks, mask_errors, color_errors);
		if (mask_errors == 0 && color_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// watchdog
	initial
	begin
		#(TIMEOUT);
		$display("timeout: tests still running after %0d ns, %0d nsprite and %0d sprdata errors",
			TIMEOUT, mask_errors, color_errors);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* denise_sprites.f */
rtl/sprite_pkg.sv
rtl/sprite_shifter.sv
rtl/sprite_priority.sv
rtl/denise_sprites.sv
dv/denise_sprites_props.sv
dv/tb_denise_sprites.sv

/* Makefile */
# Verilator build and run for the sprite block

VERILATOR ?= verilator
TOP       ?= tb_denise_sprites
FILELIST  ?= denise_sprites.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q -F '*** TEST PASSED ***' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
